//--- src/dcache_pkg.sv
package dcache_pkg;

    // line geometry
    localparam int LINE_BYTES = 32;
    localparam int BEATS      = 4;
    localparam int BEAT_BYTES = 8;
    localparam int OFFSET_W   = $clog2(LINE_BYTES);
    localparam int WAYS       = 2;

    // set field of the sram request, wide enough for 256 sets
    localparam int SET_ADDR_W = 8;

    typedef logic [31:0]                addr_t;
    typedef logic [BEAT_BYTES*8-1:0]    word_t;
    typedef logic [LINE_BYTES*8-1:0]    line_t;
    typedef logic [BEAT_BYTES-1:0]      bmask_t;
    typedef logic [$clog2(BEATS)-1:0]   beat_t;
    typedef logic [SET_ADDR_W-1:0]      set_addr_t;

    //////////////////////////////////////////////////
    // cpu port
    typedef struct packed {
        addr_t  addr;
        word_t  wdata;
        bmask_t wmask;
        logic   rd;
        logic   wr;
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;
        logic  rvalid;
        logic  bvalid;
        logic  ready;
    } cpu_rsp_t;

    //////////////////////////////////////////////////
    // memory channels
    typedef struct packed {
        addr_t addr;
        logic  valid;
    } mem_ar_t;

    typedef struct packed {
        word_t data;
        logic  valid;
        logic  last;
    } mem_r_t;

    typedef struct packed {
        addr_t addr;
        logic  valid;
    } mem_aw_t;

    typedef struct packed {
        word_t data;
        logic  valid;
        logic  last;
    } mem_w_t;

    // one request for all four macros, enables and mask active low
    typedef struct packed {
        set_addr_t          addr;
        logic [2*WAYS-1:0]  cen;
        logic [2*WAYS-1:0]  wen;
        line_t              wdata;
        line_t              mask;
    } sram_req_t;

    typedef enum logic [3:0] {
        IDLE,
        RD_HIT,
        RD_MISS,
        RD_RELOAD,
        RD_WB,
        RD_ALLOCATE,
        WR_HIT,
        WR_MISS,
        WR_RELOAD,
        WR_WB,
        WR_ALLOCATE
    } ctrl_state_t;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_ADDR,
        WB_DATA
    } wb_state_t;

endpackage

//--- src/dcache_sram.sv
module dcache_sram #(
    parameter int SETS = 64
) (
    input  logic                    I_clk,
    input  logic                    cen,
    input  logic                    wen,
    input  logic [$clog2(SETS)-1:0] addr,
    input  logic [127:0]            wdata,
    input  logic [127:0]            wmask,
    output logic [127:0]            rdata
);

    localparam int DATA_W = 128;

    logic [DATA_W-1:0] mem [SETS];

    // single port, one access per cycle
    // a low mask bit lets the matching data bit through
    always_ff @(posedge I_clk) begin
        if (!cen) begin
            if (!wen) begin
                mem[addr] <= (mem[addr] & wmask) | (wdata & ~wmask);
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

//--- src/dcache_ctrl.sv
module dcache_ctrl #(
    parameter int SETS = 64
) (
    input  logic                   I_clk,
    input  logic                   I_rst,
    input  dcache_pkg::cpu_req_t   cpu_req,
    output dcache_pkg::cpu_rsp_t   cpu_rsp,
    input  dcache_pkg::line_t      way0_rdata,
    input  dcache_pkg::line_t      way1_rdata,
    output dcache_pkg::sram_req_t  sram,
    output dcache_pkg::mem_ar_t    ar,
    input  logic                   arready,
    input  dcache_pkg::mem_r_t     r,
    output dcache_pkg::mem_aw_t    aw,
    input  logic                   awready,
    output dcache_pkg::mem_w_t     w,
    input  logic                   wready,
    input  logic                   bvalid
);

    localparam int IDX_W    = $clog2(SETS);
    localparam int OFF_W    = dcache_pkg::OFFSET_W;
    localparam int TAG_W    = 32 - IDX_W - OFF_W;
    localparam int WORD_W   = $bits(dcache_pkg::word_t);
    localparam int LINE_W   = $bits(dcache_pkg::line_t);
    localparam int WORD_LSB = $clog2(dcache_pkg::BEAT_BYTES);
    localparam int BEAT_W   = $bits(dcache_pkg::beat_t);

    localparam dcache_pkg::beat_t LAST_BEAT = dcache_pkg::beat_t'(dcache_pkg::BEATS - 1);

    // macro enables per way, active low
    localparam logic [3:0] WAY0_EN = 4'b1100;
    localparam logic [3:0] WAY1_EN = 4'b0011;
    localparam logic [3:0] NONE_EN = 4'b1111;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    function automatic logic [3:0] way_en(input logic sel1);
        return sel1 ? WAY1_EN : WAY0_EN;
    endfunction

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::ctrl_state_t state_nxt;
    dcache_pkg::wb_state_t   wb_state;
    dcache_pkg::wb_state_t   wb_state_nxt;

    // lookup tables
    tag_t            tag_tab   [dcache_pkg::WAYS][SETS];
    logic [SETS-1:0] valid_tab [dcache_pkg::WAYS];
    logic [SETS-1:0] dirty_tab [dcache_pkg::WAYS];

    // request held through a miss
    dcache_pkg::addr_t  req_addr;
    dcache_pkg::word_t  req_wdata;
    dcache_pkg::bmask_t req_mask;
    logic               way1_sel;

    dcache_pkg::line_t  line_buf;
    dcache_pkg::line_t  line_merged;
    dcache_pkg::line_t  sel_line;
    dcache_pkg::beat_t  wb_cnt;

    tag_t               in_tag;
    idx_t               in_idx;
    dcache_pkg::beat_t  in_word;
    tag_t               req_tag;
    idx_t               req_idx;
    dcache_pkg::beat_t  req_word;
    tag_t               victim_tag;

    logic hit0;
    logic hit1;
    logic hit;
    logic way1_pick;
    logic rdy;
    logic rd_hit;
    logic wr_hit;
    logic in_reload;
    logic reload_done;
    logic in_wb;
    logic in_alloc;
    logic victim_dirty;

    // sram request pieces
    idx_t                              sram_idx;
    logic [3:0]                        sram_cen;
    logic [3:0]                        sram_wen;
    dcache_pkg::line_t                 sram_wdata;
    dcache_pkg::line_t                 sram_mask;
    logic [dcache_pkg::LINE_BYTES-1:0] byte_we;

    //////////////////////////////////////////////////
    // lookup and way choice
    assign in_tag   = cpu_req.addr[31 -: TAG_W];
    assign in_idx   = cpu_req.addr[OFF_W +: IDX_W];
    assign in_word  = cpu_req.addr[WORD_LSB +: BEAT_W];
    assign req_tag  = req_addr[31 -: TAG_W];
    assign req_idx  = req_addr[OFF_W +: IDX_W];
    assign req_word = req_addr[WORD_LSB +: BEAT_W];

    assign hit0 = valid_tab[0][in_idx] && (tag_tab[0][in_idx] == in_tag);
    assign hit1 = valid_tab[1][in_idx] && (tag_tab[1][in_idx] == in_tag);
    assign hit  = hit0 || hit1;

    // hit way, else the empty way1 next to a valid way0, else way0
    assign way1_pick = hit1 || (!hit && valid_tab[0][in_idx] && !valid_tab[1][in_idx]);

    assign rdy    = state inside {dcache_pkg::IDLE, dcache_pkg::RD_HIT, dcache_pkg::WR_HIT};
    assign rd_hit = rdy && cpu_req.rd && hit;
    assign wr_hit = rdy && cpu_req.wr && hit;

    assign in_reload   = state inside {dcache_pkg::RD_RELOAD, dcache_pkg::WR_RELOAD};
    assign reload_done = in_reload && r.valid && r.last;
    assign in_wb       = state inside {dcache_pkg::RD_WB, dcache_pkg::WR_WB};
    assign in_alloc    = state inside {dcache_pkg::RD_ALLOCATE, dcache_pkg::WR_ALLOCATE};

    assign victim_dirty = dirty_tab[way1_sel][req_idx];
    assign victim_tag   = tag_tab[way1_sel][req_idx];

    // hit line in RD_HIT, victim line during write-back
    assign sel_line = way1_sel ? way1_rdata : way0_rdata;

    always_ff @(posedge I_clk) begin
        if (cpu_req.rd || cpu_req.wr) begin
            req_addr  <= cpu_req.addr;
            req_wdata <= cpu_req.wdata;
            req_mask  <= cpu_req.wmask;
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            way1_sel <= 1'b0;
        end else if (cpu_req.rd || cpu_req.wr) begin
            way1_sel <= way1_pick;
        end
    end

    //////////////////////////////////////////////////
    // tag, valid and dirty tables
    always_ff @(posedge I_clk) begin
        if (in_alloc) begin
            tag_tab[way1_sel][req_idx] <= req_tag;
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            for (int i = 0; i < dcache_pkg::WAYS; i++) begin
                valid_tab[i] <= '0;
                dirty_tab[i] <= '0;
            end
        end else begin
            if (in_alloc) begin
                valid_tab[way1_sel][req_idx] <= 1'b1;
            end
            if (wr_hit) begin
                dirty_tab[hit1][in_idx] <= 1'b1;
            end else if (in_wb && bvalid) begin
                dirty_tab[way1_sel][req_idx] <= 1'b0;
            end else if (state == dcache_pkg::WR_ALLOCATE) begin
                dirty_tab[way1_sel][req_idx] <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // line buffer
    // first beat ends up in the lowest word
    always_ff @(posedge I_clk) begin
        if (in_reload && r.valid) begin
            line_buf <= {r.data, line_buf[LINE_W-1:WORD_W]};
        end else if (state == dcache_pkg::WR_ALLOCATE) begin
            line_buf <= line_merged;
        end
    end

    // cpu word over the fetched line, byte by byte
    always_comb begin
        line_merged = line_buf;
        for (int b = 0; b < dcache_pkg::BEAT_BYTES; b++) begin
            if (req_mask[b]) begin
                line_merged[req_word*WORD_W + 8*b +: 8] = req_wdata[8*b +: 8];
            end
        end
    end

    //////////////////////////////////////////////////
    // main FSM
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state <= dcache_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            dcache_pkg::IDLE, dcache_pkg::RD_HIT, dcache_pkg::WR_HIT: begin
                if (cpu_req.rd) begin
                    state_nxt = hit ? dcache_pkg::RD_HIT : dcache_pkg::RD_MISS;
                end else if (cpu_req.wr) begin
                    state_nxt = hit ? dcache_pkg::WR_HIT : dcache_pkg::WR_MISS;
                end else begin
                    state_nxt = dcache_pkg::IDLE;
                end
            end
            dcache_pkg::RD_MISS: begin
                if (arready) begin
                    state_nxt = dcache_pkg::RD_RELOAD;
                end
            end
            dcache_pkg::RD_RELOAD: begin
                if (reload_done) begin
                    state_nxt = victim_dirty ? dcache_pkg::RD_WB : dcache_pkg::RD_ALLOCATE;
                end
            end
            dcache_pkg::RD_WB: begin
                if (bvalid) begin
                    state_nxt = dcache_pkg::RD_ALLOCATE;
                end
            end
            dcache_pkg::RD_ALLOCATE: state_nxt = dcache_pkg::IDLE;
            dcache_pkg::WR_MISS: begin
                if (arready) begin
                    state_nxt = dcache_pkg::WR_RELOAD;
                end
            end
            dcache_pkg::WR_RELOAD: begin
                if (reload_done) begin
                    state_nxt = victim_dirty ? dcache_pkg::WR_WB : dcache_pkg::WR_ALLOCATE;
                end
            end
            dcache_pkg::WR_WB: begin
                if (bvalid) begin
                    state_nxt = dcache_pkg::WR_ALLOCATE;
                end
            end
            // bvalid goes out from WR_HIT
            dcache_pkg::WR_ALLOCATE: state_nxt = dcache_pkg::WR_HIT;
            default: state_nxt = dcache_pkg::IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // write-back FSM
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            wb_state <= dcache_pkg::WB_IDLE;
            wb_cnt   <= '0;
        end else begin
            wb_state <= wb_state_nxt;
            if (w.valid && wready) begin
                wb_cnt <= wb_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        wb_state_nxt = wb_state;
        case (wb_state)
            dcache_pkg::WB_IDLE: begin
                if (reload_done && victim_dirty) begin
                    wb_state_nxt = dcache_pkg::WB_ADDR;
                end
            end
            dcache_pkg::WB_ADDR: begin
                if (awready) begin
                    wb_state_nxt = dcache_pkg::WB_DATA;
                end
            end
            dcache_pkg::WB_DATA: begin
                if (wready && wb_cnt == LAST_BEAT) begin
                    wb_state_nxt = dcache_pkg::WB_IDLE;
                end
            end
            default: wb_state_nxt = dcache_pkg::WB_IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // memory and cpu outputs
    assign ar.valid = state inside {dcache_pkg::RD_MISS, dcache_pkg::WR_MISS};
    assign ar.addr  = {req_addr[31:OFF_W], {OFF_W{1'b0}}};

    // victim address comes from its own tag
    assign aw.valid = wb_state == dcache_pkg::WB_ADDR;
    assign aw.addr  = {victim_tag, req_idx, {OFF_W{1'b0}}};

    assign w.valid = wb_state == dcache_pkg::WB_DATA;
    assign w.data  = sel_line[wb_cnt*WORD_W +: WORD_W];
    assign w.last  = w.valid && (wb_cnt == LAST_BEAT);

    assign cpu_rsp.ready  = rdy;
    assign cpu_rsp.rvalid = state inside {dcache_pkg::RD_HIT, dcache_pkg::RD_ALLOCATE};
    assign cpu_rsp.bvalid = state == dcache_pkg::WR_HIT;
    assign cpu_rsp.rdata  = (state == dcache_pkg::RD_ALLOCATE) ?
                            line_buf[req_word*WORD_W +: WORD_W] :
                            sel_line[req_word*WORD_W +: WORD_W];

    //////////////////////////////////////////////////
    // sram control
    // hits use the port on the request cycle, misses from the held request
    always_comb begin
        sram_idx   = req_idx;
        sram_cen   = NONE_EN;
        sram_wen   = NONE_EN;
        sram_wdata = line_buf;
        byte_we    = '0;
        if (rd_hit) begin
            sram_idx = in_idx;
            sram_cen = way_en(hit1);
        end else if (wr_hit) begin
            sram_idx   = in_idx;
            sram_cen   = way_en(hit1);
            sram_wen   = way_en(hit1);
            sram_wdata = {dcache_pkg::BEATS{cpu_req.wdata}};
            byte_we[in_word*dcache_pkg::BEAT_BYTES +: dcache_pkg::BEAT_BYTES] = cpu_req.wmask;
        end else if (in_alloc) begin
            sram_cen = way_en(way1_sel);
            sram_wen = way_en(way1_sel);
            if (state == dcache_pkg::WR_ALLOCATE) begin
                sram_wdata = line_merged;
            end
            byte_we = '1;
        end else if (reload_done || in_wb) begin
            // keep the victim line on the read port for the w beats
            sram_cen = way_en(way1_sel);
        end
    end

    // byte enables to an active-low bit mask
    always_comb begin
        for (int i = 0; i < dcache_pkg::LINE_BYTES; i++) begin
            sram_mask[8*i +: 8] = {8{~byte_we[i]}};
        end
    end

    assign sram.addr  = dcache_pkg::set_addr_t'(sram_idx);
    assign sram.cen   = sram_cen;
    assign sram.wen   = sram_wen;
    assign sram.wdata = sram_wdata;
    assign sram.mask  = sram_mask;

endmodule

//--- src/dcache_top.sv
module dcache_top #(
    parameter int SETS = 64
) (
    input  logic                  I_clk,
    input  logic                  I_rst,
    input  dcache_pkg::cpu_req_t  cpu_req,
    output dcache_pkg::cpu_rsp_t  cpu_rsp,
    output dcache_pkg::mem_ar_t   ar,
    input  logic                  arready,
    input  dcache_pkg::mem_r_t    r,
    output dcache_pkg::mem_aw_t   aw,
    input  logic                  awready,
    output dcache_pkg::mem_w_t    w,
    input  logic                  wready,
    input  logic                  bvalid
);

    localparam int IDX_W  = $clog2(SETS);
    localparam int HALF_W = $bits(dcache_pkg::line_t) / 2;
    localparam int MACROS = 2 * dcache_pkg::WAYS;

    dcache_pkg::sram_req_t sram;
    dcache_pkg::line_t     way0_rdata;
    dcache_pkg::line_t     way1_rdata;
    logic [HALF_W-1:0]     macro_rdata [MACROS];

    dcache_ctrl #(
        .SETS(SETS)
    ) i_ctrl (
        .I_clk      (I_clk),
        .I_rst      (I_rst),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .way0_rdata (way0_rdata),
        .way1_rdata (way1_rdata),
        .sram       (sram),
        .ar         (ar),
        .arready    (arready),
        .r          (r),
        .aw         (aw),
        .awready    (awready),
        .w          (w),
        .wready     (wready),
        .bvalid     (bvalid)
    );

    // even macros hold the low half of a line, odd ones the high half
    for (genvar i = 0; i < MACROS; i++) begin : g_macro
        dcache_sram #(
            .SETS(SETS)
        ) i_sram (
            .I_clk (I_clk),
            .cen   (sram.cen[i]),
            .wen   (sram.wen[i]),
            .addr  (sram.addr[IDX_W-1:0]),
            .wdata (sram.wdata[(i%2)*HALF_W +: HALF_W]),
            .wmask (sram.mask[(i%2)*HALF_W +: HALF_W]),
            .rdata (macro_rdata[i])
        );
    end

    assign way0_rdata = {macro_rdata[1], macro_rdata[0]};
    assign way1_rdata = {macro_rdata[3], macro_rdata[2]};

endmodule

//--- verif/dcache_mem_model.sv
module dcache_mem_model (
    input  logic                 I_clk,
    input  logic                 I_rst,
    input  dcache_pkg::mem_ar_t  ar,
    output logic                 arready,
    output dcache_pkg::mem_r_t   r,
    input  dcache_pkg::mem_aw_t  aw,
    output logic                 awready,
    input  dcache_pkg::mem_w_t   w,
    output logic                 wready,
    output logic                 bvalid,
    // record of write bursts
    output int                   burst_cnt,
    output int                   burst_beats,
    output dcache_pkg::addr_t    burst_addr,
    output dcache_pkg::line_t    burst_line
);

    // 64 KiB window of 8-byte words
    localparam int MEM_AW   = 13;
    localparam int WORD_LSB = $clog2(dcache_pkg::BEAT_BYTES);
    localparam int WORD_W   = $bits(dcache_pkg::word_t);

    dcache_pkg::word_t mem [2**MEM_AW];

    function automatic int word_idx(input dcache_pkg::addr_t a);
        return int'(a[WORD_LSB +: MEM_AW]);
    endfunction

    // each word starts out holding its own address in both halves
    initial begin
        dcache_pkg::addr_t a;
        for (int i = 0; i < 2**MEM_AW; i++) begin
            a = dcache_pkg::addr_t'(i * dcache_pkg::BEAT_BYTES);
            mem[i] = {a, a};
        end
    end

    //////////////////////////////////////////////////
    // read channel driven on the falling edge
    initial begin
        dcache_pkg::addr_t base;
        arready = 1'b0;
        r       = '0;
        forever begin
            @(negedge I_clk);
            if (!I_rst && ar.valid) begin
                repeat ($urandom_range(3)) @(negedge I_clk);
                base    = ar.addr;
                arready = 1'b1;
                @(negedge I_clk);
                arready = 1'b0;
                // beats back to back from the lowest address
                for (int i = 0; i < dcache_pkg::BEATS; i++) begin
                    r.valid = 1'b1;
                    r.last  = (i == dcache_pkg::BEATS - 1);
                    r.data  = mem[word_idx(base) + i];
                    @(negedge I_clk);
                end
                r = '0;
            end
        end
    end

    //////////////////////////////////////////////////
    // write channel
    initial begin
        dcache_pkg::addr_t base;
        logic              last;
        awready     = 1'b0;
        wready      = 1'b0;
        bvalid      = 1'b0;
        burst_cnt   = 0;
        burst_beats = 0;
        burst_addr  = '0;
        burst_line  = '0;
        forever begin
            @(negedge I_clk);
            if (!I_rst && aw.valid) begin
                repeat ($urandom_range(3)) @(negedge I_clk);
                base    = aw.addr;
                awready = 1'b1;
                @(negedge I_clk);
                awready     = 1'b0;
                burst_beats = 0;
                // w outputs hold until the next rising edge, so the beat is taken now
                do begin
                    repeat ($urandom_range(3)) @(negedge I_clk);
                    while (!w.valid) @(negedge I_clk);
                    last = w.last;
                    mem[word_idx(base) + burst_beats % 4] = w.data;
                    burst_line[(burst_beats % 4)*WORD_W +: WORD_W] = w.data;
                    wready = 1'b1;
                    @(negedge I_clk);
                    wready = 1'b0;
                    burst_beats++;
                end while (!last);
                burst_addr = base;
                burst_cnt++;
                bvalid = 1'b1;
                @(negedge I_clk);
                bvalid = 1'b0;
            end
        end
    end

endmodule

//--- verif/dcache_assertions.sv
module dcache_assertions (
    input logic                 I_clk,
    input logic                 I_rst,
    input dcache_pkg::cpu_rsp_t cpu_rsp,
    input dcache_pkg::mem_ar_t  ar,
    input logic                 arready,
    input dcache_pkg::mem_aw_t  aw,
    input logic                 awready,
    input dcache_pkg::mem_w_t   w
);

    // failed assertions so far
    int fail_cnt = 0;

    ar_hold: assert property (@(posedge I_clk) disable iff (I_rst)
        ar.valid && !arready |=> ar.valid)
    else begin
        fail_cnt++;
        $error("arvalid dropped before arready");
    end

    aw_hold: assert property (@(posedge I_clk) disable iff (I_rst)
        aw.valid && !awready |=> aw.valid)
    else begin
        fail_cnt++;
        $error("awvalid dropped before awready");
    end

    // one burst direction at a time
    ar_aw_excl: assert property (@(posedge I_clk) disable iff (I_rst)
        !(ar.valid && aw.valid))
    else begin
        fail_cnt++;
        $error("arvalid and awvalid high together");
    end

    rsp_excl: assert property (@(posedge I_clk) disable iff (I_rst)
        !(cpu_rsp.rvalid && cpu_rsp.bvalid))
    else begin
        fail_cnt++;
        $error("rvalid and bvalid high together");
    end

    wlast_valid: assert property (@(posedge I_clk) disable iff (I_rst)
        w.last |-> w.valid)
    else begin
        fail_cnt++;
        $error("wlast without wvalid");
    end

endmodule

bind dcache_ctrl dcache_assertions i_assert (
    .I_clk   (I_clk),
    .I_rst   (I_rst),
    .cpu_rsp (cpu_rsp),
    .ar      (ar),
    .arready (arready),
    .aw      (aw),
    .awready (awready),
    .w       (w)
);

//--- verif/tb_dcache.sv
module tb_dcache;

    localparam int SETS       = 64;
    localparam int SEED       = 42653;
    localparam int HALF_CYCLE = 20;
    // about twice 200 random ops at up to 40 cycles each plus the directed tests
    localparam int MAX_CYCLES = 20000;
    localparam int MEM_AW     = 13;
    localparam int WORD_LSB   = $clog2(dcache_pkg::BEAT_BYTES);
    localparam int SET_LSB    = dcache_pkg::OFFSET_W;
    localparam int TAG_LSB    = SET_LSB + $clog2(SETS);
    localparam int WORD_W     = $bits(dcache_pkg::word_t);

    logic                 I_clk;
    logic                 I_rst;
    dcache_pkg::cpu_req_t cpu_req;
    dcache_pkg::cpu_rsp_t cpu_rsp;
    dcache_pkg::mem_ar_t  ar;
    logic                 arready;
    dcache_pkg::mem_r_t   r;
    dcache_pkg::mem_aw_t  aw;
    logic                 awready;
    dcache_pkg::mem_w_t   w;
    logic                 wready;
    logic                 bvalid;
    int                   burst_cnt;
    int                   burst_beats;
    dcache_pkg::addr_t    burst_addr;
    dcache_pkg::line_t    burst_line;

    // memory as the cpu should see it
    dcache_pkg::word_t ref_mem [2**MEM_AW];

    int errors    = 0;
    int timeouts  = 0;
    int cycles    = 0;
    int ar_cycles = 0;
    int aw_cycles = 0;

    dcache_top #(
        .SETS(SETS)
    ) i_dut (
        .I_clk   (I_clk),
        .I_rst   (I_rst),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .aw      (aw),
        .awready (awready),
        .w       (w),
        .wready  (wready),
        .bvalid  (bvalid)
    );

    dcache_mem_model i_mem (
        .I_clk       (I_clk),
        .I_rst       (I_rst),
        .ar          (ar),
        .arready     (arready),
        .r           (r),
        .aw          (aw),
        .awready     (awready),
        .w           (w),
        .wready      (wready),
        .bvalid      (bvalid),
        .burst_cnt   (burst_cnt),
        .burst_beats (burst_beats),
        .burst_addr  (burst_addr),
        .burst_line  (burst_line)
    );

    initial begin
        I_clk = 1'b0;
        forever #HALF_CYCLE I_clk = ~I_clk;
    end

    //////////////////////////////////////////////////
    // helpers
    function automatic dcache_pkg::addr_t line_addr(input int tag, input int set, input int word);
        return dcache_pkg::addr_t'((tag << TAG_LSB) | (set << SET_LSB) | (word << WORD_LSB));
    endfunction

    function automatic int ref_idx(input dcache_pkg::addr_t a);
        return int'(a[WORD_LSB +: MEM_AW]);
    endfunction

    task automatic compare_value(input string sig, input logic [63:0] exp, input logic [63:0] got);
        assert (got === exp)
        else begin
            errors++;
            $display("ERR t=%0t %s expected %h got %h", $time, sig, exp, got);
        end
    endtask

    task automatic report_and_finish();
        int total;
        total = errors + i_dut.i_ctrl.i_assert.fail_cnt;
        $display("errors: %0d  timeouts: %0d", total, timeouts);
        if (total == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // watchdog and memory request counters
    always @(posedge I_clk) begin
        cycles++;
        if (ar.valid) ar_cycles++;
        if (aw.valid) aw_cycles++;
        if (cycles >= MAX_CYCLES) begin
            timeouts++;
            $display("timeout: run stopped after %0d cycles", cycles);
            report_and_finish();
        end
    end

    task automatic wait_ready();
        while (!cpu_rsp.ready) @(negedge I_clk);
    endtask

    // latency counts cycles from the request edge to rvalid
    task automatic read_word(input dcache_pkg::addr_t a, output dcache_pkg::word_t data,
                             output int lat);
        wait_ready();
        cpu_req.addr = a;
        cpu_req.rd   = 1'b1;
        @(negedge I_clk);
        cpu_req.rd = 1'b0;
        lat = 1;
        while (!cpu_rsp.rvalid) begin
            @(negedge I_clk);
            lat++;
        end
        data = cpu_rsp.rdata;
    endtask

    task automatic write_word(input dcache_pkg::addr_t a, input dcache_pkg::word_t data,
                              input dcache_pkg::bmask_t mask, output int lat);
        wait_ready();
        cpu_req.addr  = a;
        cpu_req.wdata = data;
        cpu_req.wmask = mask;
        cpu_req.wr    = 1'b1;
        // high mask bits replace bytes in the reference image
        for (int b = 0; b < dcache_pkg::BEAT_BYTES; b++) begin
            if (mask[b]) ref_mem[ref_idx(a)][8*b +: 8] = data[8*b +: 8];
        end
        @(negedge I_clk);
        cpu_req.wr = 1'b0;
        lat = 1;
        while (!cpu_rsp.bvalid) begin
            @(negedge I_clk);
            lat++;
        end
    endtask

    task automatic read_and_check(input dcache_pkg::addr_t a, input int exp_lat);
        dcache_pkg::word_t got;
        int                lat;
        read_word(a, got, lat);
        compare_value("cpu_rsp.rdata", ref_mem[ref_idx(a)], got);
        if (exp_lat > 0) compare_value("rvalid latency", exp_lat, lat);
    endtask

    //////////////////////////////////////////////////
    // directed tests
    task automatic check_reset();
        compare_value("cpu_rsp.ready", 1, cpu_rsp.ready);
        compare_value("cpu_rsp.rvalid", 0, cpu_rsp.rvalid);
        compare_value("cpu_rsp.bvalid", 0, cpu_rsp.bvalid);
        compare_value("ar.valid", 0, ar.valid);
        compare_value("aw.valid", 0, aw.valid);
        compare_value("w.valid", 0, w.valid);
    endtask

    task automatic read_miss_then_hit();
        dcache_pkg::addr_t a;
        dcache_pkg::word_t got;
        int                lat;
        int                ar_before;
        $display("read miss then hit");
        a = line_addr(1, 1, 2);
        // untouched memory word holds its own address twice
        read_word(a, got, lat);
        compare_value("cpu_rsp.rdata", {a, a}, got);
        ar_before = ar_cycles;
        read_and_check(line_addr(1, 1, 0), 1);
        compare_value("ar.valid cycles", 0, ar_cycles - ar_before);
    endtask

    task automatic write_hit_merge();
        dcache_pkg::addr_t a;
        int                lat;
        $display("write hit with partial mask");
        a = line_addr(1, 1, 3);
        write_word(a, 64'h1122_3344_5566_7788, 8'h35, lat);
        compare_value("bvalid latency", 1, lat);
        read_and_check(a, 1);
    endtask

    task automatic write_miss_allocate();
        dcache_pkg::addr_t a;
        int                lat;
        int                aw_before;
        $display("write miss to a clean set");
        a = line_addr(1, 2, 1);
        aw_before = aw_cycles;
        write_word(a, 64'hA5A5_5A5A_DEAD_BEEF, 8'hF0, lat);
        compare_value("aw.valid cycles", 0, aw_cycles - aw_before);
        read_and_check(a, 1);
    endtask

    task automatic dirty_eviction();
        dcache_pkg::addr_t victim;
        int                lat;
        int                bursts_before;
        int                ar_before;
        $display("dirty eviction");
        victim = line_addr(1, 5, 0);
        // fill way0 then way1 with dirty lines
        write_word(victim, 64'h0102_0304_0506_0708, 8'hFF, lat);
        write_word(line_addr(2, 5, 1), 64'h1111_2222_3333_4444, 8'h0F, lat);
        bursts_before = burst_cnt;
        read_and_check(line_addr(3, 5, 2), 0);
        compare_value("burst count", 1, burst_cnt - bursts_before);
        compare_value("burst beats", dcache_pkg::BEATS, burst_beats);
        compare_value("burst addr", victim, burst_addr);
        for (int i = 0; i < dcache_pkg::BEATS; i++) begin
            compare_value($sformatf("burst word %0d", i),
                          ref_mem[ref_idx(victim) + i], burst_line[i*WORD_W +: WORD_W]);
        end
        ar_before = ar_cycles;
        read_and_check(line_addr(2, 5, 1), 1);
        compare_value("ar.valid cycles", 0, ar_cycles - ar_before);
    endtask

    task automatic back_to_back_hits();
        dcache_pkg::addr_t seq [6];
        $display("back-to-back read hits");
        seq = '{line_addr(1, 1, 0), line_addr(1, 1, 1), line_addr(3, 5, 2),
                line_addr(1, 1, 3), line_addr(2, 5, 1), line_addr(1, 2, 1)};
        wait_ready();
        // each edge takes a new request and answers the previous one
        for (int i = 0; i < 6; i++) begin
            cpu_req.addr = seq[i];
            cpu_req.rd   = 1'b1;
            @(negedge I_clk);
            compare_value("cpu_rsp.rvalid", 1, cpu_rsp.rvalid);
            compare_value("cpu_rsp.rdata", ref_mem[ref_idx(seq[i])], cpu_rsp.rdata);
        end
        cpu_req.rd = 1'b0;
    endtask

    task automatic random_traffic();
        dcache_pkg::addr_t  a;
        dcache_pkg::word_t  data;
        dcache_pkg::bmask_t mask;
        int                 lat;
        $display("random reads and writes");
        for (int i = 0; i < 200; i++) begin
            a = line_addr(1 + $urandom_range(2), 16 + $urandom_range(7), $urandom_range(3));
            if ($urandom_range(1) == 1) begin
                data = {$urandom, $urandom};
                mask = dcache_pkg::bmask_t'($urandom_range(255));
                write_word(a, data, mask, lat);
            end else begin
                read_and_check(a, 0);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    initial begin
        dcache_pkg::addr_t a;
        void'($urandom(SEED));
        for (int i = 0; i < 2**MEM_AW; i++) begin
            a = dcache_pkg::addr_t'(i * dcache_pkg::BEAT_BYTES);
            ref_mem[i] = {a, a};
        end
        cpu_req = '0;
        I_rst   = 1'b1;
        repeat (2) @(posedge I_clk);
        @(negedge I_clk);
        I_rst = 1'b0;
        check_reset();
        read_miss_then_hit();
        write_hit_merge();
        write_miss_allocate();
        dirty_eviction();
        back_to_back_hits();
        random_traffic();
        repeat (2) @(negedge I_clk);
        report_and_finish();
    end

endmodule

//--- flist.f
src/dcache_pkg.sv
src/dcache_sram.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verif/dcache_mem_model.sv
verif/dcache_assertions.sv
verif/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - src/dcache_pkg.sv
  - src/dcache_sram.sv
  - src/dcache_ctrl.sv
  - src/dcache_top.sv
  - target: simulation
    files:
      - verif/dcache_mem_model.sv
      - verif/dcache_assertions.sv
      - verif/tb_dcache.sv
